// ==== tb.f ====
+incdir+.
exec_pkg.sv
exec_ifs.sv
exec_alu.sv
exec_branch.sv
exec_lsu.sv
exec_csr.sv
exec_ctrl.sv
exec_top.sv
tb_exec.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - include_dirs:
      - .
    files:
      - exec_pkg.sv
      - exec_ifs.sv
      - exec_alu.sv
      - exec_branch.sv
      - exec_lsu.sv
      - exec_csr.sv
      - exec_ctrl.sv
      - exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exec.sv

// ==== tb_exec.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module tb_exec;

    localparam int          TRAFFIC_CYCLES = 2000;
    localparam int          TIMEOUT_CYCLES = TRAFFIC_CYCLES + 50;   // Reset and drain fit in 50
    localparam int          VALID_PCT      = 70;
    localparam logic [31:0] SEED           = 32'hc5e93814;

    // One expected output set, tags name the test
    typedef struct packed {
        logic                        valid_tag;
        logic [2:0]                  unit_tag;
        logic                        result_valid;
        logic [`EXEC_XLEN-1:0]       result_data;
        logic                        rd_we;
        logic                        jump;
        logic [`EXEC_XLEN-1:0]       jump_target;
        logic                        mem_read;
        logic [`EXEC_XLEN-1:0]       mem_read_addr;
        logic [`EXEC_XLEN-1:0]       mem_write_addr;
        logic [`EXEC_XLEN-1:0]       mem_wdata;
        logic [3:0]                  mem_be;
        logic                        csr_rd_en;
        logic                        csr_wr_en;
        logic [1:0]                  csr_op;
        logic [`EXEC_CSR_ADDR_W-1:0] csr_addr;
        logic [`EXEC_XLEN-1:0]       csr_data;
        logic                        csr_exception;
    } exp_t;

    logic                        clk;
    logic                        rst_n;
    logic                        issue_valid;
    exec_pkg::exec_unit_e        issue_unit;
    exec_pkg::exec_op_e          issue_op;
    logic [`EXEC_XLEN-1:0]       op_a;
    logic [`EXEC_XLEN-1:0]       op_b;
    logic [`EXEC_XLEN-1:0]       offset;
    logic [`EXEC_XLEN-1:0]       npc;
    logic [`EXEC_XLEN-1:0]       instruction;
    exec_pkg::exec_priv_e        priv;
    logic                        result_valid;
    logic [`EXEC_XLEN-1:0]       result_data;
    logic                        rd_we;
    logic                        jump;
    logic [`EXEC_XLEN-1:0]       jump_target;
    logic                        mem_read;
    logic [`EXEC_XLEN-1:0]       mem_read_addr;
    logic [`EXEC_XLEN-1:0]       mem_write_addr;
    logic [`EXEC_XLEN-1:0]       mem_wdata;
    logic [3:0]                  mem_be;
    logic                        csr_rd_en;
    logic                        csr_wr_en;
    exec_pkg::exec_csr_op_e      csr_op;
    logic [`EXEC_CSR_ADDR_W-1:0] csr_addr;
    logic [`EXEC_XLEN-1:0]       csr_data;
    logic                        csr_exception;

    exp_t cur_exp;          // Model output for the inputs now driven
    exp_t exp_q[$];         // One entry per rising edge
    int   cycle_cnt;

    exec_top u_exec_top (.*);

    always #4 clk = ~clk;   // 8 ns period

    ////////////////////////////////////////
    // Reference model

    function automatic exp_t model_issue(input logic valid, input logic [2:0] unit,
                                         input logic [2:0] op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] off,
                                         input logic [31:0] pc, input logic [31:0] instr,
                                         input logic [1:0] prv);
        exp_t        r;
        logic [4:0]  sh;
        logic        lt_u;
        logic        lt_s;
        logic        rd_req;
        logic        wr_req;
        logic        fault;
        logic [11:0] ca;
        r          = '0;
        r.unit_tag = unit;
        sh         = b[4:0];
        lt_u       = a < b;
        lt_s       = (a[31] != b[31]) ? a[31] : lt_u;   // Sign decides if they differ
        if (valid) begin
            r.valid_tag    = 1'b1;
            r.result_valid = 1'b1;
            case (unit)
                exec_pkg::UNIT_ADD: begin
                    r.rd_we = 1'b1;
                    case (op)
                        3'd1:    r.result_data = a - b;
                        3'd2:    r.result_data = {31'd0, lt_u};
                        3'd3:    r.result_data = {31'd0, lt_s};
                        default: r.result_data = a + b;
                    endcase
                end
                exec_pkg::UNIT_LOGIC: begin
                    r.rd_we = 1'b1;
                    case (op)
                        3'd0:    r.result_data = a ^ b;
                        3'd1:    r.result_data = a | b;
                        default: r.result_data = a & b;
                    endcase
                end
                exec_pkg::UNIT_SHIFT: begin
                    r.rd_we = 1'b1;
                    case (op)
                        3'd0:    r.result_data = a << sh;
                        3'd1:    r.result_data = a >> sh;
                        default: r.result_data = (a >> sh)      // Fill vacated bits with sign
                                               | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
                    endcase
                end
                exec_pkg::UNIT_BRANCH: begin
                    r.result_data = pc + 32'd4;                 // Link for every form
                    r.rd_we       = (op >= 3'd6);
                    case (op)
                        3'd0:    r.jump = (a == b);
                        3'd1:    r.jump = (a != b);
                        3'd2:    r.jump = lt_s;
                        3'd3:    r.jump = lt_u;
                        3'd4:    r.jump = !lt_s;
                        3'd5:    r.jump = !lt_u;
                        default: r.jump = 1'b1;
                    endcase
                    case (op)
                        3'd6:    r.jump_target = a + b;
                        3'd7:    r.jump_target = (a + b) & ~32'd1;
                        default: r.jump_target = pc + off;
                    endcase
                end
                exec_pkg::UNIT_MEM: begin
                    r.mem_write_addr = a + b;
                    if (op <= 3'd4) begin                       // lb to lw
                        r.mem_read      = 1'b1;
                        r.mem_read_addr = a + b;
                        r.rd_we         = 1'b1;
                    end else begin
                        r.mem_be    = (op == 3'd5) ? 4'b0001 : (op == 3'd6) ? 4'b0011 : 4'b1111;
                        r.mem_wdata = (op == 3'd5) ? (b & 32'h0000_00ff)
                                    : (op == 3'd6) ? (b & 32'h0000_ffff) : b;
                    end
                end
                exec_pkg::UNIT_CSR: begin
                    ca         = instr[31:20];
                    rd_req     = 1'b0;
                    wr_req     = 1'b0;
                    r.csr_addr = ca;
                    r.csr_data = (op >= 3'd3 && op <= 3'd5) ? {27'd0, instr[19:15]} : a;
                    case (op)
                        3'd0, 3'd3: begin
                            r.csr_op = exec_pkg::CSR_WRITE;
                            wr_req   = 1'b1;
                            rd_req   = (instr[11:7] != 5'd0);
                        end
                        3'd1, 3'd4: begin
                            r.csr_op = exec_pkg::CSR_SET;
                            rd_req   = 1'b1;
                            wr_req   = (instr[19:15] != 5'd0);
                        end
                        3'd2, 3'd5: begin
                            r.csr_op = exec_pkg::CSR_CLEAR;
                            rd_req   = 1'b1;
                            wr_req   = (instr[19:15] != 5'd0);
                        end
                        default: r.csr_op = exec_pkg::CSR_NONE;
                    endcase
                    fault = (wr_req && ca[11:10] == 2'b11)      // Read-only space
                         || ((rd_req || wr_req) && ca[9:8] < prv);
                    r.csr_exception = fault;
                    r.csr_rd_en     = rd_req && !fault;
                    r.csr_wr_en     = wr_req && !fault;
                    r.rd_we         = r.csr_rd_en;
                end
                default: r.result_data = '0;
            endcase
        end
        return r;
    endfunction

    function automatic string unit_name(input exp_t e);
        if (!e.valid_tag) return "idle";
        case (e.unit_tag)
            3'd0:    return "adder";
            3'd1:    return "logic";
            3'd2:    return "shift";
            3'd3:    return "branch";
            3'd4:    return "mem";
            default: return "csr";
        endcase
    endfunction

    ////////////////////////////////////////
    // Stimulus and checks

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic drive_issue(input logic valid);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] instr;
        logic [31:0] rnd;
        logic [2:0]  unit_v;
        logic [2:0]  op_v;
        logic [1:0]  priv_v;
        a   = $urandom;
        b   = $urandom;
        rnd = $urandom % 8;
        case (rnd)
            0: b = a;                                   // Equal compares
            1: a[31] = 1'b1;                            // Negative shift source
            2: begin
                a[31] = 1'b1;
                b[31] = 1'b1;
            end
            3: b = 32'd0;
            default: ;
        endcase
        instr = $urandom;
        rnd   = $urandom % 4;
        if (rnd == 0) instr[11:7] = 5'd0;               // rd x0
        rnd   = $urandom % 4;
        if (rnd == 0) instr[19:15] = 5'd0;              // rs1 x0
        rnd   = $urandom % 4;
        case (rnd)
            0: instr[31:30] = 2'b11;                    // Read-only CSR
            1: instr[31:28] = 4'b0011;                  // Machine CSR
            2: instr[31:28] = 4'b0001;                  // Supervisor CSR
            default: ;
        endcase
        rnd    = $urandom % 6;
        unit_v = rnd[2:0];
        rnd    = $urandom;
        op_v   = rnd[2:0];
        rnd    = $urandom % 3;
        priv_v = (rnd == 2) ? 2'd3 : rnd[1:0];          // No reserved level
        issue_valid = valid;
        issue_unit  = exec_pkg::exec_unit_e'(unit_v);
        issue_op    = exec_pkg::exec_op_e'(op_v);
        op_a        = a;
        op_b        = b;
        offset      = $urandom;
        npc         = $urandom;
        instruction = instr;
        priv        = exec_pkg::exec_priv_e'(priv_v);
        cur_exp     = model_issue(valid, unit_v, op_v, a, b, offset, npc, instr, priv_v);
    endtask

    // Issue sampled at edge k sits in the output register after edge k+1
    always @(posedge clk) begin
        exp_q.push_back(cur_exp);
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        exp_t want;
        want = '0;                                      // Reset values until the pipe fills
        if (exp_q.size() > 1) want = exp_q.pop_front();
        check_value({unit_name(want), " result_valid"}, want.result_valid, result_valid);
        check_value({unit_name(want), " result_data"}, want.result_data, result_data);
        check_value({unit_name(want), " rd_we"}, want.rd_we, rd_we);
        check_value({unit_name(want), " jump"}, want.jump, jump);
        check_value({unit_name(want), " jump_target"}, want.jump_target, jump_target);
        check_value({unit_name(want), " mem_read"}, want.mem_read, mem_read);
        check_value({unit_name(want), " mem_read_addr"}, want.mem_read_addr, mem_read_addr);
        check_value({unit_name(want), " mem_write_addr"}, want.mem_write_addr, mem_write_addr);
        check_value({unit_name(want), " mem_wdata"}, want.mem_wdata, mem_wdata);
        check_value({unit_name(want), " mem_be"}, want.mem_be, mem_be);
        check_value({unit_name(want), " csr_rd_en"}, want.csr_rd_en, csr_rd_en);
        check_value({unit_name(want), " csr_wr_en"}, want.csr_wr_en, csr_wr_en);
        check_value({unit_name(want), " csr_op"}, want.csr_op, csr_op);
        check_value({unit_name(want), " csr_addr"}, want.csr_addr, csr_addr);
        check_value({unit_name(want), " csr_data"}, want.csr_data, csr_data);
        check_value({unit_name(want), " csr_exception"}, want.csr_exception, csr_exception);
    end

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cycle_cnt   = 0;
        cur_exp     = '0;
        issue_valid = 1'b0;
        issue_unit  = exec_pkg::UNIT_ADD;
        issue_op    = exec_pkg::OP0;
        op_a        = '0;
        op_b        = '0;
        offset      = '0;
        npc         = '0;
        instruction = '0;
        priv        = exec_pkg::PRIV_USER;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
            @(posedge clk);
            #1 drive_issue(($urandom % 100) < VALID_PCT);   // Idle cycles carry random payload
        end
        @(posedge clk);
        #1 drive_issue(1'b0);
        repeat (4) @(posedge clk);                      // Drain both stages
        @(negedge clk);
        #1;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module exec_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        issue_valid,
    input  wire exec_pkg::exec_unit_e        issue_unit,
    input  wire exec_pkg::exec_op_e          issue_op,
    input  wire logic [`EXEC_XLEN-1:0]       op_a,
    input  wire logic [`EXEC_XLEN-1:0]       op_b,
    input  wire logic [`EXEC_XLEN-1:0]       offset,
    input  wire logic [`EXEC_XLEN-1:0]       npc,
    input  wire logic [`EXEC_XLEN-1:0]       instruction,
    input  wire exec_pkg::exec_priv_e        priv,
    output wire logic                        result_valid,
    output wire logic [`EXEC_XLEN-1:0]       result_data,
    output wire logic                        rd_we,
    output wire logic                        jump,
    output wire logic [`EXEC_XLEN-1:0]       jump_target,
    output wire logic                        mem_read,
    output wire logic [`EXEC_XLEN-1:0]       mem_read_addr,
    output wire logic [`EXEC_XLEN-1:0]       mem_write_addr,
    output wire logic [`EXEC_XLEN-1:0]       mem_wdata,
    output wire logic [3:0]                  mem_be,
    output wire logic                        csr_rd_en,
    output wire logic                        csr_wr_en,
    output wire exec_pkg::exec_csr_op_e      csr_op,
    output wire logic [`EXEC_CSR_ADDR_W-1:0] csr_addr,
    output wire logic [`EXEC_XLEN-1:0]       csr_data,
    output wire logic                        csr_exception
);

    logic [`EXEC_XLEN-1:0] alu_result;     // Datapath returns
    logic [`EXEC_XLEN-1:0] br_target;
    logic [`EXEC_XLEN-1:0] br_link;
    logic                  br_taken;
    logic                  br_rd_we;

    exec_op_if op_if ();                   // Issue register contents
    lsu_req_if lsu_if ();
    csr_req_if csr_if ();

    ////////////////////////////////////////
    // Control and datapaths

    exec_ctrl u_ctrl (.op(op_if), .lsu(lsu_if), .csr(csr_if), .*);

    exec_alu u_alu (.op(op_if), .alu_result(alu_result));

    exec_branch u_branch (
        .op        (op_if),
        .br_target (br_target),
        .br_link   (br_link),
        .br_taken  (br_taken),
        .br_rd_we  (br_rd_we)
    );

    exec_lsu u_lsu (.op(op_if), .req(lsu_if));

    exec_csr u_csr (.op(op_if), .req(csr_if));

endmodule

`default_nettype wire

// ==== exec_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module exec_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        issue_valid,     // One-cycle strobe
    input  wire exec_pkg::exec_unit_e        issue_unit,
    input  wire exec_pkg::exec_op_e          issue_op,
    input  wire logic [`EXEC_XLEN-1:0]       op_a,
    input  wire logic [`EXEC_XLEN-1:0]       op_b,
    input  wire logic [`EXEC_XLEN-1:0]       offset,
    input  wire logic [`EXEC_XLEN-1:0]       npc,
    input  wire logic [`EXEC_XLEN-1:0]       instruction,
    input  wire exec_pkg::exec_priv_e        priv,
    exec_op_if.ctrl                          op,
    lsu_req_if.ctrl                          lsu,
    csr_req_if.ctrl                          csr,
    input  wire logic [`EXEC_XLEN-1:0]       alu_result,
    input  wire logic [`EXEC_XLEN-1:0]       br_target,
    input  wire logic [`EXEC_XLEN-1:0]       br_link,
    input  wire logic                        br_taken,
    input  wire logic                        br_rd_we,
    output logic                             result_valid,
    output logic [`EXEC_XLEN-1:0]            result_data,
    output logic                             rd_we,
    output logic                             jump,
    output logic [`EXEC_XLEN-1:0]            jump_target,
    output logic                             mem_read,
    output logic [`EXEC_XLEN-1:0]            mem_read_addr,
    output logic [`EXEC_XLEN-1:0]            mem_write_addr,
    output logic [`EXEC_XLEN-1:0]            mem_wdata,
    output logic [3:0]                       mem_be,
    output logic                             csr_rd_en,
    output logic                             csr_wr_en,
    output exec_pkg::exec_csr_op_e           csr_op,
    output logic [`EXEC_CSR_ADDR_W-1:0]      csr_addr,
    output logic [`EXEC_XLEN-1:0]            csr_data,
    output logic                             csr_exception
);

    logic alu_hit;    // Valid op in an ALU class
    logic br_hit;
    logic mem_hit;
    logic csr_hit;

    ////////////////////////////////////////
    // Issue register, stage 1

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin                 // Payload holds while idle
            op.unit        <= issue_unit;
            op.op          <= issue_op;
            op.op_a        <= op_a;
            op.op_b        <= op_b;
            op.offset      <= offset;
            op.npc         <= npc;
            op.instruction <= instruction;
            op.priv        <= priv;
        end
    end

    ////////////////////////////////////////
    // Unit match, gates every side effect

    assign alu_hit = op.valid && (op.unit inside {exec_pkg::UNIT_ADD,
                                                  exec_pkg::UNIT_LOGIC,
                                                  exec_pkg::UNIT_SHIFT});
    assign br_hit  = op.valid && (op.unit == exec_pkg::UNIT_BRANCH);
    assign mem_hit = op.valid && (op.unit == exec_pkg::UNIT_MEM);
    assign csr_hit = op.valid && (op.unit == exec_pkg::UNIT_CSR);

    ////////////////////////////////////////
    // Output register, stage 2

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid   <= 1'b0;
            result_data    <= '0;
            rd_we          <= 1'b0;
            jump           <= 1'b0;
            jump_target    <= '0;
            mem_read       <= 1'b0;
            mem_read_addr  <= '0;
            mem_write_addr <= '0;
            mem_wdata      <= '0;
            mem_be         <= '0;
            csr_rd_en      <= 1'b0;
            csr_wr_en      <= 1'b0;
            csr_op         <= exec_pkg::CSR_NONE;
            csr_addr       <= '0;
            csr_data       <= '0;
            csr_exception  <= 1'b0;
        end else begin
            result_valid   <= op.valid;
            result_data    <= alu_hit ? alu_result : (br_hit ? br_link : '0); // Mem and CSR give 0
            rd_we          <= alu_hit || (br_hit && br_rd_we) || (mem_hit && lsu.rd_we)
                              || (csr_hit && csr.rd_en);   // CSR writes rd only on a read
            jump           <= br_hit && br_taken;
            jump_target    <= br_hit ? br_target : '0;
            mem_read       <= mem_hit && lsu.read;
            mem_read_addr  <= mem_hit ? lsu.read_addr : '0;
            mem_write_addr <= mem_hit ? lsu.write_addr : '0;
            mem_wdata      <= mem_hit ? lsu.wdata : '0;
            mem_be         <= mem_hit ? lsu.be : '0;     // Zero for loads too
            csr_rd_en      <= csr_hit && csr.rd_en;
            csr_wr_en      <= csr_hit && csr.wr_en;
            csr_op         <= csr_hit ? csr.op : exec_pkg::CSR_NONE;
            csr_addr       <= csr_hit ? csr.addr : '0;
            csr_data       <= csr_hit ? csr.data : '0;
            csr_exception  <= csr_hit && csr.exception;
        end
    end

endmodule

`default_nettype wire

// ==== exec_csr.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module exec_csr (
    exec_op_if.dp   op,
    csr_req_if.csr  req
);

    logic [`EXEC_CSR_ADDR_W-1:0] addr;
    logic [4:0]                  rd;
    logic [4:0]                  rs1;        // Also the uimm field
    logic                        rd_req;     // Before the fault check
    logic                        wr_req;
    logic                        is_imm;
    logic                        exc;

    assign addr   = op.instruction[31:20];
    assign rd     = op.instruction[11:7];
    assign rs1    = op.instruction[19:15];
    assign is_imm = op.op inside {exec_pkg::OP3, exec_pkg::OP4, exec_pkg::OP5};

    ////////////////////////////////////////
    // Access kind per op

    always_comb begin
        rd_req = 1'b0;
        wr_req = 1'b0;
        req.op = exec_pkg::CSR_NONE;
        case (op.op)
            exec_pkg::OP0, exec_pkg::OP3: begin       // rw, rwi
                req.op = exec_pkg::CSR_WRITE;
                wr_req = 1'b1;
                rd_req = (rd != 5'd0);                // No read for rd x0
            end
            exec_pkg::OP1, exec_pkg::OP4: begin       // rs, rsi
                req.op = exec_pkg::CSR_SET;
                rd_req = 1'b1;
                wr_req = (rs1 != 5'd0);
            end
            exec_pkg::OP2, exec_pkg::OP5: begin       // rc, rci
                req.op = exec_pkg::CSR_CLEAR;
                rd_req = 1'b1;
                wr_req = (rs1 != 5'd0);
            end
            default: begin
                rd_req = 1'b0;                        // OP6, OP7 no access
            end
        endcase
    end

    // Read-only write or privilege too low
    assign exc = (wr_req && (addr[`EXEC_CSR_ADDR_W-1 -: 2] == 2'b11))
              || ((rd_req || wr_req) && (addr[9:8] < op.priv));

    assign req.rd_en     = rd_req && !exc;
    assign req.wr_en     = wr_req && !exc;
    assign req.addr      = addr;
    assign req.data      = is_imm ? {{(`EXEC_XLEN-5){1'b0}}, rs1} : op.op_a;
    assign req.exception = exc;

endmodule

`default_nettype wire

// ==== exec_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module exec_lsu (
    exec_op_if.dp   op,
    lsu_req_if.lsu  req
);

    logic [`EXEC_XLEN-1:0] addr;          // Effective address
    logic                  is_load;

    assign addr    = op.op_a + op.op_b;
    assign is_load = op.op inside {exec_pkg::OP0, exec_pkg::OP1, exec_pkg::OP2,
                                   exec_pkg::OP3, exec_pkg::OP4};

    assign req.read       = is_load;
    assign req.read_addr  = is_load ? addr : '0;
    assign req.write_addr = addr;         // Used by stores only
    assign req.rd_we      = is_load;

    // Store size, data cut to width
    always_comb begin
        case (op.op)
            exec_pkg::OP5: begin                                      // sb
                req.be    = 4'b0001;
                req.wdata = {{(`EXEC_XLEN-8){1'b0}}, op.op_b[7:0]};
            end
            exec_pkg::OP6: begin                                      // sh
                req.be    = 4'b0011;
                req.wdata = {{(`EXEC_XLEN-16){1'b0}}, op.op_b[15:0]};
            end
            exec_pkg::OP7: begin                                      // sw
                req.be    = 4'b1111;
                req.wdata = op.op_b;
            end
            default: begin                                            // Loads
                req.be    = 4'b0000;
                req.wdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_branch.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module exec_branch (
    exec_op_if.dp                  op,
    output logic [`EXEC_XLEN-1:0]  br_target,
    output logic [`EXEC_XLEN-1:0]  br_link,      // Return address
    output logic                   br_taken,
    output logic                   br_rd_we      // Jumps write rd
);

    logic [`EXEC_XLEN-1:0] jump_sum;            // op_a + op_b for jal/jalr
    logic                  is_jump;

    assign jump_sum = op.op_a + op.op_b;
    assign is_jump  = (op.op == exec_pkg::OP6) || (op.op == exec_pkg::OP7);
    assign br_link  = op.npc + `EXEC_LINK_INC;
    assign br_rd_we = is_jump;

    // Target per form
    always_comb begin
        case (op.op)
            exec_pkg::OP6: br_target = jump_sum;                            // jal
            exec_pkg::OP7: br_target = {jump_sum[`EXEC_XLEN-1:1], 1'b0};    // jalr, bit 0 low
            default:       br_target = op.npc + op.offset;                  // Conditional
        endcase
    end

    // Condition evaluation
    always_comb begin
        case (op.op)
            exec_pkg::OP0: br_taken = (op.op_a == op.op_b);                  // beq
            exec_pkg::OP1: br_taken = (op.op_a != op.op_b);                  // bne
            exec_pkg::OP2: br_taken = ($signed(op.op_a) < $signed(op.op_b)); // blt
            exec_pkg::OP3: br_taken = (op.op_a < op.op_b);                   // bltu
            exec_pkg::OP4: br_taken = ($signed(op.op_a) >= $signed(op.op_b)); // bge
            exec_pkg::OP5: br_taken = (op.op_a >= op.op_b);                  // bgeu
            default:       br_taken = 1'b1;                                  // jal, jalr
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_alu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

module exec_alu (
    exec_op_if.dp                  op,
    output logic [`EXEC_XLEN-1:0]  alu_result     // Zero outside ALU classes
);

    logic [`EXEC_XLEN-1:0] add_res;
    logic [`EXEC_XLEN-1:0] logic_res;
    logic [`EXEC_XLEN-1:0] shift_res;
    logic [4:0]            shamt;                 // Low bits of op_b

    assign shamt = op.op_b[4:0];

    // Adder class
    always_comb begin
        case (op.op)
            exec_pkg::OP1: add_res = op.op_a - op.op_b;                     // sub
            exec_pkg::OP2: add_res = {{(`EXEC_XLEN-1){1'b0}}, op.op_a < op.op_b}; // sltu
            exec_pkg::OP3: add_res = {{(`EXEC_XLEN-1){1'b0}},
                                      $signed(op.op_a) < $signed(op.op_b)}; // slt
            default:       add_res = op.op_a + op.op_b;                     // add, spares
        endcase
    end

    // Logic class
    always_comb begin
        case (op.op)
            exec_pkg::OP0: logic_res = op.op_a ^ op.op_b;
            exec_pkg::OP1: logic_res = op.op_a | op.op_b;
            default:       logic_res = op.op_a & op.op_b;
        endcase
    end

    // Shift class, sra keeps the sign
    always_comb begin
        case (op.op)
            exec_pkg::OP0: shift_res = op.op_a << shamt;
            exec_pkg::OP1: shift_res = op.op_a >> shamt;
            default:       shift_res = $signed(op.op_a) >>> shamt;
        endcase
    end

    always_comb begin
        case (op.unit)
            exec_pkg::UNIT_ADD:   alu_result = add_res;
            exec_pkg::UNIT_LOGIC: alu_result = logic_res;
            exec_pkg::UNIT_SHIFT: alu_result = shift_res;
            default:              alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exec_macros.svh"

// Operation held in the issue register
interface exec_op_if;
    logic                  valid;          // Issue register occupied
    exec_pkg::exec_unit_e  unit;
    exec_pkg::exec_op_e    op;
    logic [`EXEC_XLEN-1:0] op_a;           // rs1 or base
    logic [`EXEC_XLEN-1:0] op_b;           // rs2 or immediate
    logic [`EXEC_XLEN-1:0] offset;         // Branch immediate
    logic [`EXEC_XLEN-1:0] npc;
    logic [`EXEC_XLEN-1:0] instruction;    // Raw word, CSR fields
    exec_pkg::exec_priv_e  priv;

    modport ctrl (output valid, unit, op, op_a, op_b, offset, npc, instruction, priv);
    modport dp   (input  valid, unit, op, op_a, op_b, offset, npc, instruction, priv);
endinterface

// Load-store request from the LSU datapath
interface lsu_req_if;
    logic                  read;
    logic [`EXEC_XLEN-1:0] read_addr;      // Zero for stores
    logic [`EXEC_XLEN-1:0] write_addr;
    logic [`EXEC_XLEN-1:0] wdata;          // Low aligned, upper bits zero
    logic [3:0]            be;
    logic                  rd_we;          // Loads only

    modport lsu  (output read, read_addr, write_addr, wdata, be, rd_we);
    modport ctrl (input  read, read_addr, write_addr, wdata, be, rd_we);
endinterface

// CSR request from the CSR datapath
interface csr_req_if;
    logic                        rd_en;
    logic                        wr_en;
    exec_pkg::exec_csr_op_e      op;
    logic [`EXEC_CSR_ADDR_W-1:0] addr;
    logic [`EXEC_XLEN-1:0]       data;
    logic                        exception;    // Read-only or privilege fault

    modport csr  (output rd_en, wr_en, op, addr, data, exception);
    modport ctrl (input  rd_en, wr_en, op, addr, data, exception);
endinterface

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    ////////////////////////////////////////
    // Issue encodings

    // Unit class picked by decode
    typedef enum logic [2:0] {
        UNIT_ADD,       // add, sub, slt, sltu
        UNIT_LOGIC,     // xor, or, and
        UNIT_SHIFT,     // sll, srl, sra
        UNIT_BRANCH,    // Conditional branches and jumps
        UNIT_MEM,       // Loads and stores
        UNIT_CSR        // CSR access
    } exec_unit_e;

    // Op code inside a unit, meaning depends on the unit
    typedef enum logic [2:0] {
        OP0, OP1, OP2, OP3, OP4, OP5, OP6, OP7
    } exec_op_e;

    ////////////////////////////////////////
    // Privilege and CSR request

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_SUPER   = 2'd1,
        PRIV_MACHINE = 2'd3    // 2'd2 reserved
    } exec_priv_e;

    typedef enum logic [1:0] {
        CSR_NONE,       // No access
        CSR_WRITE,      // csrrw / csrrwi
        CSR_SET,        // csrrs / csrrsi
        CSR_CLEAR       // csrrc / csrrci
    } exec_csr_op_e;

endpackage

`default_nettype wire

// ==== exec_macros.svh ====
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data and address width
`define EXEC_XLEN 32

// CSR address field of the instruction
`define EXEC_CSR_ADDR_W 12

// Return address step for jal and jalr
`define EXEC_LINK_INC 4

`endif
